/* dv/tb_wb_tasks.svh */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// wishbone classic master, drives the testbench bus signals
// request goes out 1 ns after a rising edge, ack is looked at 1 ns after each edge

task automatic wait_ack(input string what);
  int waited;
  waited = 0;
  do begin
    @(posedge sys_clk);
    #1;
    waited++;
  end while (wb_ack !== 1'b1 && waited < ACK_TIMEOUT);
  if (wb_ack !== 1'b1) begin
    abort_run($sformatf("no wishbone ack within %0d cycles on %s", ACK_TIMEOUT, what));
  end
endtask

task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat,
                        input logic [WB_DATA_W/8-1:0] sel);
  @(posedge sys_clk);
  #1;
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = 1'b1;
  wb_adr   = adr;
  wb_dat_w = dat;
  wb_sel   = sel;
  wait_ack("write");
  wb_cyc = 1'b0;                            // drop right after ack
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [WB_DATA_W-1:0] dat);
  @(posedge sys_clk);
  #1;
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we  = 1'b0;
  wb_adr = adr;
  wb_sel = '1;
  wait_ack("read");
  dat    = wb_dat_r;                        // valid alongside ack
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

`endif

/* dv/tb_cpu_clk_subsys.sv */
`timescale 1ns/1ps

module tb_cpu_clk_subsys
  import common::*;
();

  localparam int CPU_CLK_DIV     = 2;
  localparam int RST_HOLD_CYCLES = 8;
  localparam int ACK_TIMEOUT     = 20;      // cycles per ack wait
  localparam int POLL_TIMEOUT    = 200;     // cycles for cpu reset release
  localparam int COUNT_TOL       = 3;       // cpu cycles of sync slack

  logic                   sys_clk = 1'b0;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [WB_ADDR_W-1:0]   wb_adr;
  logic [WB_DATA_W-1:0]   wb_dat_w;
  logic [WB_DATA_W/8-1:0] wb_sel;
  logic [WB_DATA_W-1:0]   wb_dat_r;
  logic                   wb_ack;
  logic                   cpu_clk;
  logic                   cpu_rst_n;

  logic [31:0] lcg_state   = 32'h3742;
  int          sys_cycle   = 0;           // free running edge count
  bit          cpu_up      = 1'b0;        // set once cpu reset has been seen released
  logic        ack_prev    = 1'b0;

  cpu_clk_subsys #(
    .CPU_CLK_DIV     (CPU_CLK_DIV),
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) uut (
    .sys_clk_i   (sys_clk),
    .rst_n_i     (rst_n),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_i    (wb_dat_w),
    .wb_sel_i    (wb_sel),
    .wb_dat_o    (wb_dat_r),
    .wb_ack_o    (wb_ack),
    .cpu_clk_o   (cpu_clk),
    .cpu_rst_n_o (cpu_rst_n)
  );

  always #50 sys_clk = ~sys_clk;            // 100 ns period

  always @(posedge sys_clk) sys_cycle <= sys_cycle + 1;

  // lcg with numerical recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // cpu cycles seen in a window of sys cycles
  function automatic logic [CNT_W-1:0] expected_cycles(input int sys_cycles);
    return CNT_W'(sys_cycles / CPU_CLK_DIV);
  endfunction

  // new bytes where sel is set and old bytes elsewhere
  function automatic logic [WB_DATA_W-1:0] lane_merge(input logic [WB_DATA_W-1:0] old_w,
      input logic [WB_DATA_W-1:0] new_w, input logic [WB_DATA_W/8-1:0] sel);
    logic [WB_DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < WB_DATA_W / 8; b++) begin
      if (sel[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [WB_DATA_W-1:0] exp,
                            input logic [WB_DATA_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    logic [CNT_W-1:0] diff;
    diff = (act > exp) ? act - exp : exp - act;
    if ($isunknown(act) || diff > CNT_W'(COUNT_TOL)) begin
      abort_run($sformatf("mismatch %s expected 0x%h (+/-%0d) actual 0x%h",
                          name, exp, COUNT_TOL, act));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
  endtask

  `include "tb_wb_tasks.svh"

  // cpu clock is high for the first half of every CPU_CLK_DIV sys cycles
  task automatic scan_cpu_clk(input int n);
    logic prev;
    int   waited;
    prev   = 1'b1;
    waited = 0;
    while (!(prev === 1'b0 && cpu_clk === 1'b1)) begin  // look for a rising sample
      if (waited > 2 * CPU_CLK_DIV) abort_run("cpu clock is not toggling");
      prev = cpu_clk;
      @(posedge sys_clk);
      #1;
      waited++;
    end
    for (int i = 0; i < n; i++) begin
      check_bit("cpu_clk_o", (i % CPU_CLK_DIV) < CPU_CLK_DIV / 2, cpu_clk);
      @(posedge sys_clk);
      #1;
    end
  endtask

  // every status read checks lock once the cpu is up
  task automatic read_status(output logic [WB_DATA_W-1:0] data);
    wb_read(REG_STATUS, data);
    if (cpu_up) check_bit("status locked bit", 1'b1, data[STAT_LOCKED_BIT]);
  endtask

  // control write that notes the ack cycle and reads back run and clear
  task automatic write_ctrl(input logic [WB_DATA_W-1:0] val, output int ack_cycle);
    logic [WB_DATA_W-1:0] rd;
    wb_write(REG_CTRL, val, '1);
    ack_cycle = sys_cycle;
    wb_read(REG_CTRL, rd);
    check_word("wb_dat_o (ctrl)", val & 32'h3, rd);
  endtask

  // ack is one cycle wide and cpu reset stays released once up
  always @(negedge sys_clk) begin
    if (ack_prev === 1'b1 && wb_ack === 1'b1) begin
      abort_run("wishbone ack stayed high for more than one cycle");
    end
    ack_prev = wb_ack;
    if (cpu_up) check_bit("cpu_rst_n_o", 1'b1, cpu_rst_n);
  end

  initial begin : main_seq
    logic [WB_DATA_W-1:0]   rd;
    logic [WB_DATA_W-1:0]   rd2;
    logic [WB_DATA_W-1:0]   wdata;
    logic [WB_DATA_W-1:0]   scratch_model;
    logic [WB_DATA_W/8-1:0] sel;
    int                     t_start;
    int                     t_stop;
    int                     t0;
    int                     run_len;

    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    repeat (16) @(posedge sys_clk);
    #1 rst_n = 1'b1;

    // reset defaults
    check_bit("wb_ack_o", 1'b0, wb_ack);
    wb_read(REG_CTRL, rd);
    check_word("wb_dat_o (ctrl)", '0, rd);
    wb_read(REG_SCRATCH, rd);
    check_word("wb_dat_o (scratch)", '0, rd);
    wb_read(REG_CYCLES, rd);
    check_word("wb_dat_o (cycles)", '0, rd);

    // poll for cpu reset release
    t0 = sys_cycle;
    rd = '0;
    while (rd[STAT_CPU_RUN_BIT] !== 1'b1) begin
      if (sys_cycle - t0 > POLL_TIMEOUT) abort_run("cpu reset not released within 200 cycles");
      read_status(rd);
    end
    cpu_up = 1'b1;
    check_bit("cpu_rst_n_o", 1'b1, cpu_rst_n);
    check_bit("status locked bit", 1'b1, rd[STAT_LOCKED_BIT]);

    scan_cpu_clk(4 * CPU_CLK_DIV);

    // scratch with random byte lanes
    scratch_model = '0;
    for (int i = 0; i < 10; i++) begin
      wdata = next_rand();
      sel   = 4'(next_rand() >> 12);
      wb_write(REG_SCRATCH, wdata, sel);
      scratch_model = lane_merge(scratch_model, wdata, sel);
      wb_read(REG_SCRATCH, rd);
      check_word("wb_dat_o (scratch)", scratch_model, rd);
    end
    read_status(rd);

    // count over a random window with junk in the upper ctrl bits
    wdata = (next_rand() & ~32'h3) | 32'h1;
    write_ctrl(wdata, t_start);
    run_len = 40 + int'((next_rand() >> 8) % 161);
    wait_cycles(run_len);
    wdata = next_rand() & ~32'h3;
    write_ctrl(wdata, t_stop);
    wait_cycles(20);
    wb_read(REG_CYCLES, rd);
    check_count("wb_dat_o (cycles)", expected_cycles(t_stop - t_start), rd);
    wait_cycles(30);
    wb_read(REG_CYCLES, rd2);
    check_word("wb_dat_o (cycles stopped)", rd, rd2);   // frozen while stopped

    // clear and then restart
    wdata = (next_rand() & ~32'h3) | 32'h2;
    write_ctrl(wdata, t0);
    wait_cycles(20);
    wb_read(REG_CYCLES, rd);
    check_word("wb_dat_o (cycles cleared)", '0, rd);
    wdata = (next_rand() & ~32'h3) | 32'h1;
    write_ctrl(wdata, t0);
    wait_cycles(20);
    wb_read(REG_CYCLES, rd);
    if (rd === '0 || $isunknown(rd)) abort_run("cycles register still zero after restart");
    wait_cycles(30);
    wb_read(REG_CYCLES, rd2);
    if ($isunknown(rd2) || rd2 <= rd) abort_run("cycles register did not rise after restart");

    write_ctrl('0, t0);
    read_status(rd);
    check_bit("status cpu run bit", 1'b1, rd[STAT_CPU_RUN_BIT]);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+dv
src/common_pkg.sv
src/cpu_clk_gen.sv
src/cpu_rst_sync.sv
src/cpu_cycle_counter.sv
src/sys_wb_regs.sv
src/cpu_clk_subsys.sv
dv/tb_cpu_clk_subsys.sv

/* src/common_pkg.sv */
package common;

  // wishbone bus geometry
  localparam int WB_DATA_W = 32;            // data word width
  localparam int WB_ADDR_W = 2;             // word address, four registers

  // register map, word indices
  localparam logic [WB_ADDR_W-1:0] REG_CTRL    = 2'd0;  // run / clear
  localparam logic [WB_ADDR_W-1:0] REG_STATUS  = 2'd1;  // locked / cpu running
  localparam logic [WB_ADDR_W-1:0] REG_CYCLES  = 2'd2;  // cpu cycle count
  localparam logic [WB_ADDR_W-1:0] REG_SCRATCH = 2'd3;  // free r/w word

  // control register bits
  localparam int CTRL_RUN_BIT   = 0;        // counter enable
  localparam int CTRL_CLEAR_BIT = 1;        // counter held at zero

  // status register bits
  localparam int STAT_LOCKED_BIT  = 0;      // cpu clock ready
  localparam int STAT_CPU_RUN_BIT = 1;      // cpu out of reset

  // cycle counter width, same as the bus word
  localparam int CNT_W = 32;

  // build switch for the clock generator
  // 1 selects the PLL and global buffer, 0 the behavioral divider
  localparam bit USE_VENDOR_PRIMS = 1'b0;

endpackage

/* src/cpu_clk_gen.sv */
`timescale 1ns/1ps

module cpu_clk_gen
  import common::*;
#(
  parameter int CPU_CLK_DIV = 2             // sys clk to cpu clk ratio, even only
) (
  input  logic sys_clk_i,                   // 100 MHz board clock
  output logic cpu_clk_o,                   // derived cpu clock
  output logic ready_async_o                // clock usable, not synchronized
);

  localparam int HALF  = CPU_CLK_DIV / 2;          // sys cycles per half period
  localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;

  // free running, no reset, power up value only
  logic [DIV_W-1:0] div_cnt = '0;
  logic             clk_q   = 1'b0;

  always_ff @(posedge sys_clk_i) begin
    if (div_cnt == DIV_W'(HALF - 1)) begin
      div_cnt <= '0;
      clk_q   <= ~clk_q;                    // half period done
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  assign cpu_clk_o     = clk_q;
  assign ready_async_o = 1'b1;              // divider is good from the first edge

endmodule

/* src/cpu_clk_subsys.sv */
`timescale 1ns/1ps

module cpu_clk_subsys
  import common::*;
#(
  parameter int CPU_CLK_DIV     = 2,        // even ratio, sys to cpu
  parameter int RST_HOLD_CYCLES = 8         // cpu cycles of extra reset
) (
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,
  // host wishbone port
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [WB_ADDR_W-1:0]   wb_adr_i,
  input  logic [WB_DATA_W-1:0]   wb_dat_i,
  input  logic [WB_DATA_W/8-1:0] wb_sel_i,
  output logic [WB_DATA_W-1:0]   wb_dat_o,
  output logic                   wb_ack_o,
  // cpu clock and reset out
  output logic                   cpu_clk_o,
  output logic                   cpu_rst_n_o
);

  logic             ready_async;            // clock ready, not synced
  logic             run;                    // sys domain level
  logic             clear;                  // sys domain level
  logic [CNT_W-1:0] cnt_gray;               // cpu domain count, gray

  // clock source, pll or divider
  cpu_clk_gen #(
    .CPU_CLK_DIV (CPU_CLK_DIV)
  ) u_clk_gen (
    .sys_clk_i     (sys_clk_i),
    .cpu_clk_o     (cpu_clk_o),
    .ready_async_o (ready_async)
  );

  // cpu reset release after clock ready
  cpu_rst_sync #(
    .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
  ) u_rst_sync (
    .cpu_clk_i     (cpu_clk_o),
    .rst_n_i       (rst_n_i),
    .ready_async_i (ready_async),
    .cpu_rst_n_o   (cpu_rst_n_o)
  );

  cpu_cycle_counter u_cycle_counter (
    .cpu_clk_i   (cpu_clk_o),
    .cpu_rst_n_i (cpu_rst_n_o),
    .run_i       (run),
    .clear_i     (clear),
    .cnt_gray_o  (cnt_gray)
  );

  // host registers, system domain
  sys_wb_regs u_wb_regs (
    .sys_clk_i     (sys_clk_i),
    .rst_n_i       (rst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .ready_async_i (ready_async),
    .cpu_rst_n_i   (cpu_rst_n_o),
    .cnt_gray_i    (cnt_gray),
    .run_o         (run),
    .clear_o       (clear)
  );

endmodule

/* src/cpu_cycle_counter.sv */
`timescale 1ns/1ps

module cpu_cycle_counter
  import common::*;
(
  input  logic             cpu_clk_i,
  input  logic             cpu_rst_n_i,     // cpu domain, sync active low
  input  logic             run_i,           // level from system domain
  input  logic             clear_i,         // level from system domain
  output logic [CNT_W-1:0] cnt_gray_o       // gray count for the system side
);

  logic [1:0]       run_sync_q;             // run synchronizer
  logic [1:0]       clear_sync_q;           // clear synchronizer
  logic             run_s;
  logic             clear_s;
  logic [CNT_W-1:0] cnt_q;                  // binary count
  logic [CNT_W-1:0] gray_q;

  // level sync of run and clear
  always_ff @(posedge cpu_clk_i) begin
    if (!cpu_rst_n_i) begin
      run_sync_q   <= '0;
      clear_sync_q <= '0;
    end else begin
      run_sync_q   <= {run_sync_q[0], run_i};
      clear_sync_q <= {clear_sync_q[0], clear_i};
    end
  end

  assign run_s   = run_sync_q[1];
  assign clear_s = clear_sync_q[1];

  // clear wins over run, wraps at 2**CNT_W
  always_ff @(posedge cpu_clk_i) begin
    if (!cpu_rst_n_i || clear_s) begin
      cnt_q <= '0;
    end else if (run_s) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  // registered gray, one bit moves per count step
  always_ff @(posedge cpu_clk_i) begin
    if (!cpu_rst_n_i) begin
      gray_q <= '0;
    end else begin
      gray_q <= cnt_q ^ (cnt_q >> 1);
    end
  end

  assign cnt_gray_o = gray_q;

endmodule

/* src/cpu_rst_sync.sv */
`timescale 1ns/1ps

module cpu_rst_sync #(
  parameter int RST_HOLD_CYCLES = 8         // cpu cycles held after release
) (
  input  logic cpu_clk_i,
  input  logic rst_n_i,                     // system reset, other domain
  input  logic ready_async_i,               // clock ready, async
  output logic cpu_rst_n_o                  // cpu domain reset, active low
);

  localparam int HOLD_W = (RST_HOLD_CYCLES > 1) ? $clog2(RST_HOLD_CYCLES) : 1;

  logic              release_async;         // both conditions met
  logic [1:0]        release_sync_q;        // two flop sync
  logic              release_s;
  logic [HOLD_W-1:0] hold_cnt;
  logic              rst_n_q;

  assign release_async = rst_n_i & ready_async_i;

  // bring release into the cpu domain
  always_ff @(posedge cpu_clk_i) begin
    release_sync_q <= {release_sync_q[0], release_async};
  end

  assign release_s = release_sync_q[1];

  // hold count, restarts whenever release drops
  always_ff @(posedge cpu_clk_i) begin
    if (!release_s) begin
      hold_cnt <= '0;
      rst_n_q  <= 1'b0;                     // drop at once
    end else if (hold_cnt == HOLD_W'(RST_HOLD_CYCLES - 1)) begin
      rst_n_q  <= 1'b1;                     // hold done, release cpu
    end else begin
      hold_cnt <= hold_cnt + HOLD_W'(1);
    end
  end

  assign cpu_rst_n_o = rst_n_q;

endmodule

/* src/sys_wb_regs.sv */
`timescale 1ns/1ps

module sys_wb_regs
  import common::*;
(
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,
  // wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [WB_ADDR_W-1:0]   wb_adr_i,
  input  logic [WB_DATA_W-1:0]   wb_dat_i,
  input  logic [WB_DATA_W/8-1:0] wb_sel_i,
  output logic [WB_DATA_W-1:0]   wb_dat_o,
  output logic                   wb_ack_o,
  // from the cpu domain
  input  logic                   ready_async_i,
  input  logic                   cpu_rst_n_i,
  input  logic [CNT_W-1:0]       cnt_gray_i,
  // levels to the counter
  output logic                   run_o,
  output logic                   clear_o
);

  localparam int SEL_W = WB_DATA_W / 8;     // byte lanes

  logic                 req;                // new request this cycle
  logic                 ack_q;
  logic [WB_DATA_W-1:0] dat_q;              // read data valid with ack
  logic [WB_DATA_W-1:0] rd_data;
  logic [1:0]           ctrl_q;             // run and clear only
  logic [WB_DATA_W-1:0] scratch_q;

  logic [1:0]           ready_sync_q;
  logic [1:0]           cpu_rst_sync_q;
  logic [CNT_W-1:0]     gray_s1_q;          // gray sync stage 1
  logic [CNT_W-1:0]     gray_s2_q;          // gray sync stage 2
  logic [CNT_W-1:0]     cnt_bin;            // decoded count

  // skip the cycle where ack is already up
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  // single cycle ack one cycle after request
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // byte lane 0 holds both control bits
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (req && wb_we_i && wb_adr_i == REG_CTRL && wb_sel_i[0]) begin
      ctrl_q[CTRL_RUN_BIT]   <= wb_dat_i[CTRL_RUN_BIT];
      ctrl_q[CTRL_CLEAR_BIT] <= wb_dat_i[CTRL_CLEAR_BIT];
    end
  end

  // scratch written per byte
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      scratch_q <= '0;
    end else if (req && wb_we_i && wb_adr_i == REG_SCRATCH) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (wb_sel_i[b]) begin
          scratch_q[b*8 +: 8] <= wb_dat_i[b*8 +: 8];
        end
      end
    end
  end

  // cpu side status and count into this domain
  always_ff @(posedge sys_clk_i) begin
    if (!rst_n_i) begin
      ready_sync_q   <= '0;
      cpu_rst_sync_q <= '0;
      gray_s1_q      <= '0;
      gray_s2_q      <= '0;
    end else begin
      ready_sync_q   <= {ready_sync_q[0], ready_async_i};
      cpu_rst_sync_q <= {cpu_rst_sync_q[0], cpu_rst_n_i};
      gray_s1_q      <= cnt_gray_i;
      gray_s2_q      <= gray_s1_q;
    end
  end

  // gray to binary from the msb down
  always_comb begin
    cnt_bin[CNT_W-1] = gray_s2_q[CNT_W-1];
    for (int i = CNT_W - 2; i >= 0; i--) begin
      cnt_bin[i] = cnt_bin[i+1] ^ gray_s2_q[i];
    end
  end

  // unmapped read bits are zero
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_CTRL: begin
        rd_data[CTRL_RUN_BIT]   = ctrl_q[CTRL_RUN_BIT];
        rd_data[CTRL_CLEAR_BIT] = ctrl_q[CTRL_CLEAR_BIT];
      end
      REG_STATUS: begin
        rd_data[STAT_LOCKED_BIT]  = ready_sync_q[1];
        rd_data[STAT_CPU_RUN_BIT] = cpu_rst_sync_q[1];
      end
      REG_CYCLES:  rd_data = cnt_bin;
      REG_SCRATCH: rd_data = scratch_q;
    endcase
  end

  // capture read data with the ack edge
  always_ff @(posedge sys_clk_i) begin
    if (req) begin
      dat_q <= rd_data;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;
  assign run_o    = ctrl_q[CTRL_RUN_BIT];
  assign clear_o  = ctrl_q[CTRL_CLEAR_BIT];

endmodule
